/* logic/ccu_pkg.sv */
/*
 * Shared sizes and state encodings for the instruction-fetch CCU.
 * The line size must be a whole number of memory beats and the
 * queue depth must be a power of two so the index width is exact.
 * Addresses passed between blocks are line addresses without offset.
 */

package ccu_pkg;

    // Address and line geometry
    localparam int ADDR_WIDTH      = 32;
    localparam int LINE_BYTES      = 16;
    localparam int OFFSET_WIDTH    = $clog2(LINE_BYTES);
    localparam int LINE_ADDR_WIDTH = ADDR_WIDTH - OFFSET_WIDTH;
    localparam int LINE_WIDTH      = LINE_BYTES * 8;

    // Memory beats
    localparam int MEM_DATA_WIDTH  = 32;
    localparam int BEATS_PER_LINE  = LINE_WIDTH / MEM_DATA_WIDTH;
    localparam int BEAT_IDX_WIDTH  = $clog2(BEATS_PER_LINE);

    // Instruction fetch queue
    localparam int IFQ_DEPTH       = 4;
    localparam int IFQ_IDX_WIDTH   = $clog2(IFQ_DEPTH);

    typedef enum logic [1:0] {
        INVALID = 2'b00,
        VALID   = 2'b01
    } ifq_entry_state_t;

    typedef enum logic [1:0] {
        IDLE = 2'b00,
        REQ  = 2'b01,
        WAIT = 2'b10
    } mem_req_state_t;

endpackage

/* logic/ifq_entry.sv */
/*
 * Single IFQ slot with a two-state occupancy FSM.
 * The stored line address is only meaningful while o_valid is high.
 * i_alloc_en and i_done are never expected in the same cycle.
 */

`timescale 1ns/1ps

module ifq_entry import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_arst_n,

    input  logic                       i_alloc_en,
    input  logic [LINE_ADDR_WIDTH-1:0] i_alloc_addr,
    input  logic                       i_done,

    output logic                       o_valid,
    output logic [LINE_ADDR_WIDTH-1:0] o_addr
);

    ifq_entry_state_t state_r;
    ifq_entry_state_t state_next;
    logic [LINE_ADDR_WIDTH-1:0] addr_r;

    always_comb begin
        state_next = state_r;
        case (state_r)
            INVALID: if (i_alloc_en) state_next = VALID;
            VALID:   if (i_done) state_next = INVALID;
            default: state_next = INVALID;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r <= INVALID;
        end else begin
            state_r <= state_next;
        end
    end

    // Address captured on allocation only
    always_ff @(posedge clk) begin
        if (i_alloc_en) begin
            addr_r <= i_alloc_addr;
        end
    end

    assign o_valid = (state_r != INVALID);
    assign o_addr  = addr_r;

endmodule

/* logic/ifq.sv */
/*
 * Instruction fetch queue holding outstanding line misses.
 * A miss that matches a valid entry, or arrives while full, is dropped
 * without any indication back to the cache.
 * Entries are served strictly in allocation order through the head.
 */

`timescale 1ns/1ps

module ifq import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_arst_n,

    input  logic                       i_miss_en,
    input  logic [LINE_ADDR_WIDTH-1:0] i_miss_addr,
    input  logic                       i_line_done,

    output logic                       o_ifq_full,
    output logic                       o_head_valid,
    output logic [LINE_ADDR_WIDTH-1:0] o_head_addr
);

    logic [IFQ_DEPTH-1:0]       entry_valid;
    logic [LINE_ADDR_WIDTH-1:0] entry_addr [IFQ_DEPTH];
    logic [IFQ_DEPTH-1:0]       entry_alloc;
    logic [IFQ_DEPTH-1:0]       entry_done;
    logic [IFQ_DEPTH-1:0]       addr_match;

    logic [IFQ_IDX_WIDTH-1:0] head_r;
    logic [IFQ_IDX_WIDTH-1:0] tail_r;
    logic                     full;
    logic                     alloc;

    genvar gi;
    generate
        for (gi = 0; gi < IFQ_DEPTH; gi++) begin : g_entry
            // Hit only against occupied slots
            assign addr_match[gi]  = entry_valid[gi] && (entry_addr[gi] == i_miss_addr);
            assign entry_alloc[gi] = alloc && (tail_r == IFQ_IDX_WIDTH'(gi));
            assign entry_done[gi]  = i_line_done && (head_r == IFQ_IDX_WIDTH'(gi));

            ifq_entry u_entry (
                .clk          (clk),
                .i_arst_n     (i_arst_n),
                .i_alloc_en   (entry_alloc[gi]),
                .i_alloc_addr (i_miss_addr),
                .i_done       (entry_done[gi]),
                .o_valid      (entry_valid[gi]),
                .o_addr       (entry_addr[gi])
            );
        end
    endgenerate

    assign full  = &entry_valid;
    assign alloc = i_miss_en && !full && !(|addr_match);

    // Head and tail wrap at the last slot
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            head_r <= '0;
            tail_r <= '0;
        end else begin
            if (alloc) begin
                tail_r <= (tail_r == IFQ_IDX_WIDTH'(IFQ_DEPTH - 1)) ? '0 : tail_r + 1'b1;
            end
            if (i_line_done) begin
                head_r <= (head_r == IFQ_IDX_WIDTH'(IFQ_DEPTH - 1)) ? '0 : head_r + 1'b1;
            end
        end
    end

    assign o_ifq_full   = full;
    assign o_head_valid = entry_valid[head_r];
    assign o_head_addr  = entry_addr[head_r];

endmodule

/* logic/ccu_mem_req.sv */
/*
 * Memory request sequencer for the IFQ head entry.
 * Only one line fetch is outstanding at a time; the FSM holds in WAIT
 * until the line assembler reports completion.
 * o_mem_addr is stable from the request cycle until the next request.
 */

`timescale 1ns/1ps

module ccu_mem_req import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_arst_n,

    input  logic                       i_head_valid,
    input  logic [LINE_ADDR_WIDTH-1:0] i_head_addr,
    input  logic                       i_line_done,

    output logic                       o_mem_req,
    output logic [LINE_ADDR_WIDTH-1:0] o_mem_addr
);

    mem_req_state_t state_r;
    mem_req_state_t state_next;
    logic [LINE_ADDR_WIDTH-1:0] addr_r;

    always_comb begin
        state_next = state_r;
        case (state_r)
            IDLE:    if (i_head_valid) state_next = REQ;
            REQ:     state_next = WAIT;
            WAIT:    if (i_line_done) state_next = IDLE;
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            state_r <= IDLE;
        end else begin
            state_r <= state_next;
        end
    end

    // Head address sampled as the request is launched
    always_ff @(posedge clk) begin
        if (state_r == IDLE && i_head_valid) begin
            addr_r <= i_head_addr;
        end
    end

    // Request pulse lasts exactly the single REQ cycle
    assign o_mem_req  = (state_r == REQ);
    assign o_mem_addr = addr_r;

endmodule

/* logic/ccu_line_assembler.sv */
/*
 * Collects BEATS_PER_LINE memory beats into one cache line.
 * Beat 0 lands in the lowest MEM_DATA_WIDTH bits of the line.
 * Beats outside a request window are ignored; memory errors are not handled.
 * Fill and done pulse together the cycle after the last beat.
 */

`timescale 1ns/1ps

module ccu_line_assembler import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_arst_n,

    input  logic                       i_mem_req,
    input  logic [LINE_ADDR_WIDTH-1:0] i_mem_addr,
    input  logic                       i_mem_data_valid,
    input  logic [MEM_DATA_WIDTH-1:0]  i_mem_data,

    output logic                       o_fill_en,
    output logic [LINE_ADDR_WIDTH-1:0] o_fill_addr,
    output logic [LINE_WIDTH-1:0]      o_fill_data,
    output logic                       o_line_done
);

    logic                       busy_r;
    logic [BEAT_IDX_WIDTH-1:0]  beat_cnt_r;
    logic                       fill_r;
    logic [LINE_ADDR_WIDTH-1:0] addr_r;
    logic [LINE_WIDTH-1:0]      line_r;
    logic                       beat_en;
    logic                       last_beat;

    assign beat_en   = busy_r && i_mem_data_valid;
    assign last_beat = beat_en && (beat_cnt_r == BEAT_IDX_WIDTH'(BEATS_PER_LINE - 1));

    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            busy_r     <= 1'b0;
            beat_cnt_r <= '0;
            fill_r     <= 1'b0;
        end else begin
            fill_r <= last_beat;
            if (i_mem_req) begin
                busy_r     <= 1'b1;
                beat_cnt_r <= '0;
            end else if (beat_en) begin
                beat_cnt_r <= beat_cnt_r + 1'b1;
                if (last_beat) busy_r <= 1'b0;
            end
        end
    end

    // Line payload and address
    always_ff @(posedge clk) begin
        if (i_mem_req) begin
            addr_r <= i_mem_addr;
        end
        if (beat_en) begin
            line_r[beat_cnt_r * MEM_DATA_WIDTH +: MEM_DATA_WIDTH] <= i_mem_data;
        end
    end

    assign o_fill_en   = fill_r;
    assign o_line_done = fill_r;
    assign o_fill_addr = addr_r;
    assign o_fill_data = line_r;

endmodule

/* logic/ccu_ifetch_top.sv */
/*
 * Instruction-fetch side of the CCU: miss queue, memory sequencer
 * and line assembler. The cache must accept every fill; there is
 * no back-pressure on o_fill_en. Dropped misses are not reported.
 */

`timescale 1ns/1ps

module ccu_ifetch_top import ccu_pkg::*; (
    input  logic                       clk,
    input  logic                       i_arst_n,

    input  logic                       i_miss_en,
    input  logic [LINE_ADDR_WIDTH-1:0] i_miss_addr,
    output logic                       o_ifq_full,

    output logic                       o_mem_req,
    output logic [LINE_ADDR_WIDTH-1:0] o_mem_addr,
    input  logic                       i_mem_data_valid,
    input  logic [MEM_DATA_WIDTH-1:0]  i_mem_data,

    output logic                       o_fill_en,
    output logic [LINE_ADDR_WIDTH-1:0] o_fill_addr,
    output logic [LINE_WIDTH-1:0]      o_fill_data
);

    logic                       head_valid;
    logic [LINE_ADDR_WIDTH-1:0] head_addr;
    logic                       mem_req;
    logic [LINE_ADDR_WIDTH-1:0] mem_addr;
    logic                       line_done;

    ifq u_ifq (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_miss_en    (i_miss_en),
        .i_miss_addr  (i_miss_addr),
        .i_line_done  (line_done),
        .o_ifq_full   (o_ifq_full),
        .o_head_valid (head_valid),
        .o_head_addr  (head_addr)
    );

    ccu_mem_req u_mem_req (
        .clk          (clk),
        .i_arst_n     (i_arst_n),
        .i_head_valid (head_valid),
        .i_head_addr  (head_addr),
        .i_line_done  (line_done),
        .o_mem_req    (mem_req),
        .o_mem_addr   (mem_addr)
    );

    // Request pulse also opens the assembler capture window
    ccu_line_assembler u_line_asm (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_mem_req        (mem_req),
        .i_mem_addr       (mem_addr),
        .i_mem_data_valid (i_mem_data_valid),
        .i_mem_data       (i_mem_data),
        .o_fill_en        (o_fill_en),
        .o_fill_addr      (o_fill_addr),
        .o_fill_data      (o_fill_data),
        .o_line_done      (line_done)
    );

    assign o_mem_req  = mem_req;
    assign o_mem_addr = mem_addr;

endmodule

/* test/ccu_clkgen.sv */
/*
 * Free-running testbench clock that starts low.
 * The period is given in ns and should be even.
 */

`timescale 1ns/1ps

module ccu_clkgen #(
    parameter int PERIOD_NS = 10
) (
    output logic o_clk
);

    initial begin
        o_clk = 1'b0;
        forever #(PERIOD_NS / 2) o_clk = ~o_clk;
    end

endmodule

/* test/ccu_chk.sv */
/*
 * Protocol checks on the CCU top level, attached with bind.
 * Assumes the fill strobe always closes the fetch that the
 * preceding memory request opened.
 */

`timescale 1ns/1ps

module ccu_chk (
    input  logic clk,
    input  logic i_arst_n,
    input  logic i_mem_req,
    input  logic i_fill_en,
    input  logic i_ifq_full
);

    logic fetch_open_r;
    int   fail_cnt = 0;

    // Open from the request until the end of the fill cycle
    always_ff @(posedge clk or negedge i_arst_n) begin
        if (!i_arst_n) begin
            fetch_open_r <= 1'b0;
        end else if (i_mem_req) begin
            fetch_open_r <= 1'b1;
        end else if (i_fill_en) begin
            fetch_open_r <= 1'b0;
        end
    end

    a_fill_one_cycle: assert property (@(posedge clk) disable iff (!i_arst_n)
        i_fill_en |=> !i_fill_en)
        else begin
            $error("fill strobe held longer than one cycle");
            fail_cnt++;
        end

    a_one_fetch: assert property (@(posedge clk) disable iff (!i_arst_n)
        fetch_open_r |-> !i_mem_req)
        else begin
            $error("memory request issued before the previous line was filled");
            fail_cnt++;
        end

    a_reset_quiet: assert property (@(posedge clk)
        !i_arst_n |-> !(i_mem_req || i_fill_en || i_ifq_full))
        else begin
            $error("request, fill or full active during reset");
            fail_cnt++;
        end

endmodule

/* test/ccu_tb.sv */
/*
 * Testbench for the instruction-fetch CCU top level.
 * Commands come from test/ccu_stim.txt, so the run starts in the project root.
 * The memory model answers every request with BEATS_PER_LINE beats, each
 * after 0 to 3 idle cycles. Beat k of a line is {line address, k}.
 */

`timescale 1ns/1ps

module ccu_tb import ccu_pkg::*; ();

    localparam int          STIM_WORDS = 64;
    localparam logic [31:0] STIM_END   = 32'hFFFF_FFFF;

    logic                       clk;
    logic                       i_arst_n;
    logic                       i_miss_en;
    logic [LINE_ADDR_WIDTH-1:0] i_miss_addr;
    logic                       o_ifq_full;
    logic                       o_mem_req;
    logic [LINE_ADDR_WIDTH-1:0] o_mem_addr;
    logic                       i_mem_data_valid;
    logic [MEM_DATA_WIDTH-1:0]  i_mem_data;
    logic                       o_fill_en;
    logic [LINE_ADDR_WIDTH-1:0] o_fill_addr;
    logic [LINE_WIDTH-1:0]      o_fill_data;

    logic [31:0]                stim [STIM_WORDS];
    logic [LINE_ADDR_WIDTH-1:0] accepted [$];
    int                         req_cnt;
    int                         fill_cnt;
    int                         expected_fills;
    int                         watchdog_cycles;
    logic [7:0]                 lfsr;

    ccu_clkgen #(.PERIOD_NS(10)) u_clkgen (.o_clk(clk));

    ccu_ifetch_top uut (
        .clk              (clk),
        .i_arst_n         (i_arst_n),
        .i_miss_en        (i_miss_en),
        .i_miss_addr      (i_miss_addr),
        .o_ifq_full       (o_ifq_full),
        .o_mem_req        (o_mem_req),
        .o_mem_addr       (o_mem_addr),
        .i_mem_data_valid (i_mem_data_valid),
        .i_mem_data       (i_mem_data),
        .o_fill_en        (o_fill_en),
        .o_fill_addr      (o_fill_addr),
        .o_fill_data      (o_fill_data)
    );

    bind ccu_ifetch_top ccu_chk u_chk (
        .clk        (clk),
        .i_arst_n   (i_arst_n),
        .i_mem_req  (o_mem_req),
        .i_fill_en  (o_fill_en),
        .i_ifq_full (o_ifq_full)
    );

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1, "simulation stopped at the first error");
    endtask

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_next(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    function automatic logic [MEM_DATA_WIDTH-1:0] beat_word(
        input logic [LINE_ADDR_WIDTH-1:0] a, input int k);
        return {a, 4'(k)};
    endfunction

    function automatic logic [LINE_WIDTH-1:0] line_for(input logic [LINE_ADDR_WIDTH-1:0] a);
        logic [LINE_WIDTH-1:0] line;
        for (int k = 0; k < BEATS_PER_LINE; k++) begin
            line[k*MEM_DATA_WIDTH +: MEM_DATA_WIDTH] = beat_word(a, k);
        end
        return line;
    endfunction

    // A line in its fill cycle still counts as pending
    function automatic bit is_pending(input logic [LINE_ADDR_WIDTH-1:0] a);
        for (int j = fill_cnt; j < accepted.size(); j++) begin
            if (accepted[j] == a) return 1'b1;
        end
        return o_fill_en && (o_fill_addr == a);
    endfunction

    // Memory model
    always begin : mem_model
        logic [LINE_ADDR_WIDTH-1:0] addr;
        logic [1:0]                 gap;
        @(negedge clk);
        if (i_arst_n && o_mem_req) begin
            assert (req_cnt < accepted.size()) else
                stop_with_error("Memory request issued while no miss was pending");
            assert (o_mem_addr == accepted[req_cnt]) else
                stop_with_error($sformatf("** Error at %0t: o_mem_addr expected %h, got %h",
                    $time, accepted[req_cnt], o_mem_addr));
            addr = o_mem_addr;
            req_cnt++;
            for (int k = 0; k < BEATS_PER_LINE; k++) begin
                lfsr = lfsr_next(lfsr);
                gap[0] = lfsr[0];
                lfsr = lfsr_next(lfsr);
                gap[1] = lfsr[0];
                @(negedge clk);
                i_mem_data_valid = 1'b0;
                repeat (gap) @(negedge clk);
                i_mem_data_valid = 1'b1;
                i_mem_data = beat_word(addr, k);
            end
            @(negedge clk);
            i_mem_data_valid = 1'b0;
        end
    end

    // Queue occupancy and fill checks
    always @(negedge clk) begin
        if (i_arst_n) begin
            assert (o_ifq_full == (accepted.size() - fill_cnt == IFQ_DEPTH)) else
                stop_with_error($sformatf("** Error at %0t: o_ifq_full expected %0b, got %0b",
                    $time, accepted.size() - fill_cnt == IFQ_DEPTH, o_ifq_full));
            if (o_fill_en) begin
                assert (fill_cnt < req_cnt) else
                    stop_with_error("Fill seen without an outstanding memory request");
                assert (o_fill_addr == accepted[fill_cnt]) else
                    stop_with_error($sformatf("** Error at %0t: o_fill_addr expected %h, got %h",
                        $time, accepted[fill_cnt], o_fill_addr));
                assert (o_fill_data == line_for(accepted[fill_cnt])) else
                    stop_with_error($sformatf("** Error at %0t: o_fill_data expected %h, got %h",
                        $time, line_for(accepted[fill_cnt]), o_fill_data));
                fill_cnt++;
            end
        end
    end

    // Bound protocol checker
    always @(negedge clk) begin
        assert (uut.u_chk.fail_cnt == 0) else
            stop_with_error("A protocol assertion in the bound checker failed");
    end

    initial begin : watchdog
        wait (watchdog_cycles > 0);
        repeat (watchdog_cycles) @(posedge clk);
        stop_with_error("Watchdog timeout, the run did not finish in time");
    end

    initial begin : driver
        int          n;
        int          idle_sum;
        logic [3:0]  cmd;
        logic [27:0] arg;
        bit          take;
        i_arst_n         = 1'b0;
        i_miss_en        = 1'b0;
        i_miss_addr      = '0;
        i_mem_data_valid = 1'b0;
        i_mem_data       = '0;
        lfsr             = 8'd71;
        req_cnt          = 0;
        fill_cnt         = 0;
        expected_fills   = -1;
        // Words past the end of the file keep the end marker
        foreach (stim[i]) begin
            stim[i] = STIM_END;
        end
        $readmemh("test/ccu_stim.txt", stim);
        n = 0;
        idle_sum = 0;
        while (n < STIM_WORDS && stim[n] != STIM_END) begin
            if (stim[n][31:28] == 4'h0) idle_sum += int'(stim[n][27:0]);
            n++;
        end
        assert (n > 0) else stop_with_error("Stimulus file is missing or empty");
        watchdog_cycles = n * 40 + idle_sum + 100;
        repeat (3) @(posedge clk);
        @(negedge clk);
        i_arst_n = 1'b1;
        for (int i = 0; i < n; i++) begin
            cmd = stim[i][31:28];
            arg = stim[i][27:0];
            case (cmd)
                4'h0: repeat (arg) @(negedge clk);
                4'h1: begin
                    i_miss_en   = 1'b1;
                    i_miss_addr = arg;
                    take = !o_ifq_full && !is_pending(arg);
                    @(posedge clk);
                    if (take) accepted.push_back(arg);
                    @(negedge clk);
                    i_miss_en = 1'b0;
                end
                // Returns inside the fill cycle
                4'h2: while (!o_fill_en) @(negedge clk);
                4'h3: expected_fills = int'(arg);
                default: stop_with_error("Unknown command in stimulus file");
            endcase
        end
        while (fill_cnt != accepted.size()) @(negedge clk);
        repeat (4) @(negedge clk);
        assert (fill_cnt == expected_fills) else
            stop_with_error($sformatf("** Error at %0t: o_fill_en count expected %0d, got %0d",
                $time, expected_fills, fill_cnt));
        $display("** PASS **");
        $finish;
    end

endmodule

/* test/ccu_stim.txt */
// One hex word per line, [31:28] command and [27:0] argument
// Commands 0 idle cycles, 1 miss line address, 2 wait for fill, 3 expected fill total
0_0000002
1_0001000
2_0000000
1_0001000
0_0000014
1_0002000
1_0002001
1_0002002
1_0002003
1_0002004
2_0000000
1_0002000
1_0002003
1_0003000
0_0000080
1_0002000
0_0000003
1_0004000
0_0000001
1_0004000
1_0005000
0_0000005
3_0000009

/* ccu_ifetch_top.f */
logic/ccu_pkg.sv
logic/ifq_entry.sv
logic/ifq.sv
logic/ccu_mem_req.sv
logic/ccu_line_assembler.sv
logic/ccu_ifetch_top.sv
test/ccu_clkgen.sv
test/ccu_chk.sv
test/ccu_tb.sv

/* run_sim.sh */
#!/bin/sh
# Builds the CCU testbench with Verilator and runs it from the project root

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert --top-module ccu_tb -f ccu_ifetch_top.f -o ccu_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/ccu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "\*\* FAIL \*\*" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

echo "Simulation finished without failure"
exit 0
